// File: all.f
+incdir+hw
hw/memSystemPkg.sv
hw/cacheWay.sv
hw/fourBankMem.sv
hw/cacheController.sv
hw/memSystem.sv
testbench/memSystemTb.sv

// File: testbench/memSystemTb.sv
`timescale 1ns/1ps

module memSystemTb;
    import memSystemPkg::*;

    localparam int Timeout = 60;    // Cycles allowed for one request
    localparam int NumRandom = 400;

    logic clk;
    logic reset;
    addrT addr;
    wordT dataIn;
    logic rd;
    logic wr;
    wordT dataOut;
    logic done;
    logic stall;
    logic cacheHit;
    logic err;

    // Reference model of main memory and the cache directory
    wordT memModel [32768];
    tagT  tagModel0 [256];
    tagT  tagModel1 [256];
    logic [255:0] validModel0;
    logic [255:0] validModel1;
    logic victimModel;

    logic [31:0] lfsrState;

    memSystem i_dut (
        .clk, .reset, .addr, .dataIn, .rd, .wr,
        .dataOut, .done, .stall, .cacheHit, .err
    );

    always #10 clk = ~clk;

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsrStep(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic takeBits(input int n, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < n; i++) begin
            lfsrState = lfsrStep(lfsrState);
            value = {value[30:0], lfsrState[0]};
        end
    endtask

    function automatic addrT makeAddr(input tagT t, input indexT ix, input offsetT off);
        return {t, ix, off, 1'b0};
    endfunction

    task automatic stopOnError();
        $display("Test failed");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic checkValue(input string name, input wordT got, input wordT expected);
        assert (got === expected) else begin
            $display("[FAIL] %s: got %h, expected %h (addr %h)", name, got, expected, addr);
            stopOnError();
        end
    endtask

    // Outputs expected quiet while no request is raised
    task automatic checkQuiet();
        checkValue("done", wordT'(done), 16'h0);
        checkValue("stall", wordT'(stall), 16'h0);
        checkValue("cacheHit", wordT'(cacheHit), 16'h0);
        checkValue("err", wordT'(err), 16'h0);
    endtask

    task automatic doRequest(input logic isWrite, input addrT a, input wordT d);
        tagT     t;
        indexT   ix;
        memAddrT wa;
        logic    hitWay0;
        logic    hitWay1;
        logic    expHit;
        logic    expErr;
        wordT    expData;
        int      cycles;
        logic    sawDone;

        t       = a[15:11];
        ix      = a[10:3];
        wa      = a[15:1];
        expErr  = a[0];
        hitWay0 = validModel0[ix] && (tagModel0[ix] == t);
        hitWay1 = validModel1[ix] && (tagModel1[ix] == t);
        expHit  = !expErr && !isWrite && (hitWay0 || hitWay1);
        expData = memModel[wa];

        @(posedge clk);
        addr   <= a;
        dataIn <= d;
        rd     <= !isWrite;
        wr     <= isWrite;

        // The first negedge comes before the DUT samples the request
        cycles  = 0;
        sawDone = 1'b0;
        while (!sawDone) begin
            @(negedge clk);
            cycles++;
            if (done) begin
                sawDone = 1'b1;
            end else begin
                if (cycles >= 2) begin
                    checkValue("stall", wordT'(stall), 16'h1);
                end
                assert (cycles < Timeout) else begin
                    $display("Request at address %h did not finish within %0d cycles",
                             a, Timeout);
                    stopOnError();
                end
            end
        end

        checkValue("stall", wordT'(stall), 16'h0);
        checkValue("err", wordT'(err), wordT'(expErr));
        checkValue("cacheHit", wordT'(cacheHit), wordT'(expHit));
        if (!isWrite && !expErr) begin
            checkValue("dataOut", dataOut, expData);
        end
        if (expHit || expErr) begin
            assert (cycles == 3) else begin
                $display("Done for address %h came %0d cycles after sampling, not 2",
                         a, cycles - 1);
                stopOnError();
            end
        end

        @(posedge clk);
        rd <= 1'b0;
        wr <= 1'b0;

        // Write-through model with no allocation on a write miss
        if (!expErr) begin
            if (isWrite) begin
                memModel[wa] = d;
            end else if (!(hitWay0 || hitWay1)) begin
                if (!validModel0[ix] || (validModel1[ix] && !victimModel)) begin
                    validModel0[ix] = 1'b1;
                    tagModel0[ix]   = t;
                end else begin
                    validModel1[ix] = 1'b1;
                    tagModel1[ix]   = t;
                end
            end
        end
        victimModel = ~victimModel;    // Toggles on every done
    endtask

    task automatic randomRequest();
        logic [31:0] bits;
        tagT    t;
        indexT  ix;
        offsetT off;
        logic   isWrite;
        logic   odd;
        wordT   d;
        int     gap;

        takeBits(1, bits);
        isWrite = bits[0];
        takeBits(2, bits);
        case (bits[1:0])
            2'd0: t = 5'h00;
            2'd1: t = 5'h07;
            2'd2: t = 5'h13;
            default: t = 5'h1e;
        endcase
        takeBits(2, bits);
        case (bits[1:0])
            2'd0: ix = 8'h00;
            2'd1: ix = 8'h09;
            2'd2: ix = 8'h5a;
            default: ix = 8'hff;
        endcase
        takeBits(2, bits);
        off = bits[1:0];
        takeBits(4, bits);
        odd = (bits[3:0] == 4'h0);     // About one in sixteen
        takeBits(16, bits);
        d = bits[15:0];
        takeBits(2, bits);
        gap = int'(bits[1:0]);

        repeat (gap) begin
            @(negedge clk);
            checkQuiet();
        end
        doRequest(isWrite, makeAddr(t, ix, off) | addrT'(odd), d);
    endtask

    initial begin
        clk         = 1'b0;
        reset       = 1'b1;
        addr        = '0;
        dataIn      = '0;
        rd          = 1'b0;
        wr          = 1'b0;
        lfsrState   = 32'h3849c20a;
        victimModel = 1'b0;
        validModel0 = '0;
        validModel1 = '0;
        for (int i = 0; i < 32768; i++) begin
            memModel[i] = wordT'(i);
        end

        repeat (16) @(posedge clk);
        reset <= 1'b0;
        repeat (6) begin
            @(negedge clk);
            checkQuiet();
        end

        // Cold miss, then hits anywhere in the line
        doRequest(1'b0, makeAddr(5'h02, 8'h10, 2'd1), 16'h0);
        doRequest(1'b0, makeAddr(5'h02, 8'h10, 2'd3), 16'h0);
        doRequest(1'b0, makeAddr(5'h02, 8'h10, 2'd1), 16'h0);

        // Write hit, then a write miss that must not allocate
        doRequest(1'b1, makeAddr(5'h02, 8'h10, 2'd2), 16'hbeef);
        doRequest(1'b0, makeAddr(5'h02, 8'h10, 2'd2), 16'h0);
        doRequest(1'b1, makeAddr(5'h04, 8'h21, 2'd0), 16'h1234);
        doRequest(1'b0, makeAddr(5'h04, 8'h21, 2'd0), 16'h0);
        doRequest(1'b0, makeAddr(5'h04, 8'h21, 2'd3), 16'h0);

        // Three tags in one set force an eviction
        doRequest(1'b0, makeAddr(5'h01, 8'h33, 2'd0), 16'h0);
        doRequest(1'b0, makeAddr(5'h05, 8'h33, 2'd1), 16'h0);
        doRequest(1'b0, makeAddr(5'h09, 8'h33, 2'd2), 16'h0);
        doRequest(1'b0, makeAddr(5'h01, 8'h33, 2'd3), 16'h0);
        doRequest(1'b0, makeAddr(5'h05, 8'h33, 2'd0), 16'h0);
        doRequest(1'b0, makeAddr(5'h09, 8'h33, 2'd1), 16'h0);

        // Odd byte addresses are refused
        doRequest(1'b0, makeAddr(5'h02, 8'h10, 2'd1) | 16'h1, 16'h0);
        doRequest(1'b1, makeAddr(5'h02, 8'h10, 2'd2) | 16'h1, 16'hdead);
        doRequest(1'b0, makeAddr(5'h02, 8'h10, 2'd2), 16'h0);

        for (int n = 0; n < NumRandom; n++) begin
            randomRequest();
        end

        repeat (4) begin
            @(negedge clk);
            checkQuiet();
        end

        $display("Test passed");
        $finish;
    end

endmodule

// File: hw/memSystem.sv
`timescale 1ns/1ps

module memSystem (
    input  logic                   clk,
    input  logic                   reset,
    input  memSystemPkg::addrT     addr,
    input  memSystemPkg::wordT     dataIn,
    input  logic                   rd,
    input  logic                   wr,
    output memSystemPkg::wordT     dataOut,
    output logic                   done,
    output logic                   stall,
    output logic                   cacheHit,
    output logic                   err
);
    import memSystemPkg::*;

    // Shared lookup bus to both ways
    indexT  index;
    tagT    tag;
    offsetT offset;
    wordT   writeData;

    logic writeWord0;
    logic writeWord1;
    logic setValid0;
    logic setValid1;
    logic hit0;
    logic hit1;
    wordT readData0;
    wordT readData1;

    // Controller to banked memory
    memAddrT    memAddr;
    wordT       memWriteData;
    logic       memRd;
    logic       memWr;
    logic [3:0] busy;
    logic       readValid;
    bankT       readBank;
    wordT       readData;

    cacheController ctrl (
        .clk, .reset, .addr, .dataIn, .rd, .wr,
        .hit0, .hit1, .readData0, .readData1,
        .busy, .readValid, .readBank, .readData,
        .dataOut, .done, .stall, .cacheHit, .err,
        .index, .tag, .offset, .writeData,
        .writeWord0, .writeWord1, .setValid0, .setValid1,
        .memAddr, .memWriteData, .memRd, .memWr
    );

    cacheWay way0 (
        .clk, .reset, .index, .tag, .offset, .writeData,
        .writeWord (writeWord0),
        .setValid  (setValid0),
        .hit       (hit0),
        .readData  (readData0)
    );

    cacheWay way1 (
        .clk, .reset, .index, .tag, .offset, .writeData,
        .writeWord (writeWord1),
        .setValid  (setValid1),
        .hit       (hit1),
        .readData  (readData1)
    );

    fourBankMem mem (
        .clk, .reset, .memAddr, .memWriteData, .memRd, .memWr,
        .busy, .readValid, .readBank, .readData
    );

endmodule

// File: hw/cacheController.sv
`timescale 1ns/1ps
`include "memSystem_params.svh"

module cacheController (
    input  logic                   clk,
    input  logic                   reset,
    input  memSystemPkg::addrT     addr,
    input  memSystemPkg::wordT     dataIn,
    input  logic                   rd,
    input  logic                   wr,
    input  logic                   hit0,
    input  logic                   hit1,
    input  memSystemPkg::wordT     readData0,
    input  memSystemPkg::wordT     readData1,
    input  logic [3:0]             busy,
    input  logic                   readValid,
    input  memSystemPkg::bankT     readBank,
    input  memSystemPkg::wordT     readData,
    output memSystemPkg::wordT     dataOut,
    output logic                   done,
    output logic                   stall,
    output logic                   cacheHit,
    output logic                   err,
    output memSystemPkg::indexT    index,
    output memSystemPkg::tagT      tag,
    output memSystemPkg::offsetT   offset,
    output memSystemPkg::wordT     writeData,
    output logic                   writeWord0,
    output logic                   writeWord1,
    output logic                   setValid0,
    output logic                   setValid1,
    output memSystemPkg::memAddrT  memAddr,
    output memSystemPkg::wordT     memWriteData,
    output logic                   memRd,
    output logic                   memWr
);
    import memSystemPkg::*;

    ctrlStateT state;

    logic misaligned;    // Odd byte address seen in idle
    logic refilled;      // Line was fetched for this request
    logic victim;
    logic fillWay;
    logic [2:0] issueCount;
    logic [2:0] returnCount;

    // Copy of each way's valid bits, for the replacement choice
    logic [`MS_SETS-1:0] validMap0;
    logic [`MS_SETS-1:0] validMap1;

    bankT issueBank;
    bankT reqBank;
    logic anyHit;
    logic chooseWay;
    logic issueNow;
    logic lastReturn;
    logic writeAccept;
    logic inFill;

    assign tag     = addr[15:11];
    assign index   = addr[10:3];
    assign reqBank = addr[2:1];
    assign inFill  = (state == fill);

    // Returned words land at the offset of their bank
    assign offset    = inFill ? readBank : reqBank;
    assign writeData = inFill ? readData : dataIn;
    assign anyHit    = hit0 | hit1;

    // Write hits update the way, fill returns go to the victim
    assign writeWord0 = ((state == compareTag) && wr && !misaligned && hit0)
                        || (inFill && readValid && !fillWay);
    assign writeWord1 = ((state == compareTag) && wr && !misaligned && hit1)
                        || (inFill && readValid && fillWay);
    assign setValid0  = (state == allocate) && !fillWay;
    assign setValid1  = (state == allocate) && fillWay;

    // Way 0 first, then way 1, then the victim bit
    assign chooseWay = !validMap0[index] ? 1'b0 : (!validMap1[index] ? 1'b1 : victim);

    assign issueBank   = issueCount[1:0];
    assign issueNow    = inFill && (issueCount != 3'(`MS_LINE_WORDS)) && !busy[issueBank];
    assign lastReturn  = readValid && (returnCount == 3'(`MS_LINE_WORDS - 1));
    assign writeAccept = (state == writeMem) && !busy[reqBank];

    assign memRd        = issueNow;
    assign memWr        = writeAccept;
    assign memAddr      = inFill ? {tag, index, issueBank} : addr[15:1];
    assign memWriteData = dataIn;

    assign done  = (state == doneWait);
    assign stall = (state != idle) && !done;   // Low in idle and during done

    always_ff @(posedge clk) begin
        if (reset) begin
            state       <= idle;
            misaligned  <= 1'b0;
            refilled    <= 1'b0;
            victim      <= 1'b0;
            fillWay     <= 1'b0;
            issueCount  <= '0;
            returnCount <= '0;
            cacheHit    <= 1'b0;
            err         <= 1'b0;
        end else begin
            case (state)
                idle: begin
                    if (rd || wr) begin
                        misaligned <= addr[0];
                        refilled   <= 1'b0;
                        state      <= compareTag;
                    end
                end
                compareTag: begin
                    if (misaligned) begin
                        err   <= 1'b1;
                        state <= doneWait;
                    end else if (wr) begin
                        state <= writeMem;      // No allocation on a write miss
                    end else if (anyHit) begin
                        cacheHit <= !refilled;
                        state    <= doneWait;
                    end else begin
                        fillWay     <= chooseWay;
                        issueCount  <= '0;
                        returnCount <= '0;
                        refilled    <= 1'b1;
                        state       <= fill;
                    end
                end
                fill: begin
                    if (issueNow) begin
                        issueCount <= issueCount + 3'd1;
                    end
                    if (readValid) begin
                        returnCount <= returnCount + 3'd1;
                    end
                    if (lastReturn) begin
                        state <= allocate;
                    end
                end
                allocate: state <= compareTag;   // Valid is set this cycle
                writeMem: begin
                    if (writeAccept) begin
                        state <= doneWait;
                    end
                end
                doneWait: begin
                    // Request is ignored here so the requester can drop it
                    victim   <= ~victim;
                    cacheHit <= 1'b0;
                    err      <= 1'b0;
                    state    <= idle;
                end
                default: state <= idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            validMap0 <= '0;
            validMap1 <= '0;
        end else begin
            if (setValid0) validMap0[index] <= 1'b1;
            if (setValid1) validMap1[index] <= 1'b1;
        end
    end

    // Hit word held for the done cycle
    always_ff @(posedge clk) begin
        if ((state == compareTag) && anyHit) begin
            dataOut <= hit1 ? readData1 : readData0;
        end
    end

endmodule

// File: hw/fourBankMem.sv
`timescale 1ns/1ps
`include "memSystem_params.svh"

module fourBankMem (
    input  logic                   clk,
    input  logic                   reset,
    input  memSystemPkg::memAddrT  memAddr,
    input  memSystemPkg::wordT     memWriteData,
    input  logic                   memRd,
    input  logic                   memWr,
    output logic [3:0]             busy,
    output logic                   readValid,
    output memSystemPkg::bankT     readBank,
    output memSystemPkg::wordT     readData
);
    import memSystemPkg::*;

    localparam int RowBits   = $clog2(`MS_BANK_WORDS);
    localparam int TimerBits = $clog2(`MS_BANK_BUSY + 1);
    localparam int Depth     = `MS_READ_LATENCY;

    wordT bankMem [4][`MS_BANK_WORDS];

    // Return pipeline, stage Depth-1 drives the outputs
    logic [Depth-1:0] pipeValid;
    bankT pipeBank [Depth];
    wordT pipeData [Depth];

    bankT bankSel;
    logic [RowBits-1:0] row;
    logic accept;
    logic acceptRd;
    logic acceptWr;

    // Low word-address bits interleave consecutive words across banks
    assign bankSel = memAddr[1:0];
    assign row     = memAddr[14:2];

    assign accept   = (memRd || memWr) && !busy[bankSel];
    assign acceptWr = accept && memWr;
    assign acceptRd = accept && memRd && !memWr;

    // Each word starts out holding its own word address
    initial begin
        for (int b = 0; b < 4; b++) begin
            for (int r = 0; r < `MS_BANK_WORDS; r++) begin
                bankMem[b][r] = memAddrT'(r * 4 + b);
            end
        end
    end

    always @(posedge clk) begin
        if (acceptWr) begin
            bankMem[bankSel][row] <= memWriteData;
        end
    end

    genvar g;
    generate
        for (g = 0; g < 4; g++) begin : bankTimer
            logic [TimerBits-1:0] busyCount;

            always_ff @(posedge clk) begin
                if (reset) begin
                    busyCount <= '0;
                end else if (accept && (bankSel == bankT'(g))) begin
                    busyCount <= TimerBits'(`MS_BANK_BUSY);
                end else if (busyCount != '0) begin
                    busyCount <= busyCount - 1'b1;
                end
            end

            assign busy[g] = (busyCount != '0);
        end
    endgenerate

    always_ff @(posedge clk) begin
        if (reset) begin
            pipeValid <= '0;
        end else begin
            pipeValid <= (pipeValid << 1) | Depth'(acceptRd);
        end
    end

    // Data is read when the access is accepted, then shifted along
    always_ff @(posedge clk) begin
        pipeBank[0] <= bankSel;
        pipeData[0] <= bankMem[bankSel][row];
        for (int i = 1; i < Depth; i++) begin
            pipeBank[i] <= pipeBank[i-1];
            pipeData[i] <= pipeData[i-1];
        end
    end

    assign readValid = pipeValid[Depth-1];
    assign readBank  = pipeBank[Depth-1];
    assign readData  = pipeData[Depth-1];

endmodule

// File: hw/cacheWay.sv
`timescale 1ns/1ps
`include "memSystem_params.svh"

module cacheWay (
    input  logic                   clk,
    input  logic                   reset,
    input  memSystemPkg::indexT    index,
    input  memSystemPkg::tagT      tag,
    input  memSystemPkg::offsetT   offset,
    input  memSystemPkg::wordT     writeData,
    input  logic                   writeWord,
    input  logic                   setValid,
    output logic                   hit,
    output memSystemPkg::wordT     readData
);
    import memSystemPkg::*;

    // One tag and one valid bit per set
    tagT  tagMem [`MS_SETS];
    logic [`MS_SETS-1:0] validBits;

    // Four words per line
    wordT dataMem [`MS_SETS][`MS_LINE_WORDS];

    logic tagMatch;

    always_ff @(posedge clk) begin
        if (reset) begin
            validBits <= '0;
        end else if (setValid) begin
            validBits[index] <= 1'b1;
        end
    end

    // Tag is written together with the valid bit
    always_ff @(posedge clk) begin
        if (setValid) begin
            tagMem[index] <= tag;
        end
    end

    // Word writes come from write hits and from line fills
    always_ff @(posedge clk) begin
        if (writeWord) begin
            dataMem[index][offset] <= writeData;
        end
    end

    assign tagMatch = (tagMem[index] == tag);
    assign hit      = validBits[index] && tagMatch;   // Stale tags never hit

    assign readData = dataMem[index][offset];

endmodule

// File: hw/memSystemPkg.sv
package memSystemPkg;

    // Byte address from the pipeline
    typedef logic [15:0] addrT;
    typedef logic [15:0] wordT;

    // Address split for the cache
    typedef logic [4:0]  tagT;      // addr[15:11]
    typedef logic [7:0]  indexT;    // addr[10:3]
    typedef logic [1:0]  offsetT;   // addr[2:1], also picks the bank

    typedef logic [1:0]  bankT;
    typedef logic [14:0] memAddrT;  // Word address into main memory

    // Controller FSM
    typedef enum logic [2:0] {
        idle,
        compareTag,
        fill,        // Line reads in flight
        allocate,
        writeMem,    // Waiting for the bank on a write-through
        doneWait
    } ctrlStateT;

endpackage

// File: hw/memSystem_params.svh
`ifndef MEM_SYSTEM_PARAMS_SVH
`define MEM_SYSTEM_PARAMS_SVH

// Cache geometry
`define MS_SETS        256
`define MS_WAYS        2     // The design is built for two ways
`define MS_LINE_WORDS  4

// Banked main memory
`define MS_BANK_WORDS  8192  // Words in each of the four banks

// Cycles a bank is held after it accepts an access
`define MS_BANK_BUSY   4

// Accepted read to readValid
`define MS_READ_LATENCY 2

`endif
